// File: analogizer_video_pkg.sv
// Video path package with pixel, DAC and mode types and the YPbPr matrix coefficients
package analogizer_video_pkg;

	typedef logic [7:0] pixel_t; // Core colour channel, 8 bits
	typedef logic [5:0] dac_t;   // DAC channel, upper six bits of a pixel

	// Output standard sent to the DAC
	typedef enum logic [1:0] {
		MODE_RGBS  = 2'd0, // Separate composite sync on HS pin
		MODE_RGSB  = 2'd1, // Sync on green through the SOG switch
		MODE_YPBPR = 2'd2, // Component, Pr on R, Y on G, Pb on B
		MODE_TEST  = 2'd3  // Solid blue screen
	} video_mode_t;

	localparam int VIDEO_LATENCY = 3; // Input edge to bank pins, in i_clk cycles

	// Colour matrix, scaled by 256
	localparam logic signed [9:0] Y_R  = 10'sd77;
	localparam logic signed [9:0] Y_G  = 10'sd150;
	localparam logic signed [9:0] Y_B  = 10'sd29;
	localparam logic signed [9:0] PB_R = -10'sd43;
	localparam logic signed [9:0] PB_G = -10'sd85;
	localparam logic signed [9:0] PB_B = 10'sd128;
	localparam logic signed [9:0] PR_R = 10'sd128;
	localparam logic signed [9:0] PR_G = -10'sd107;
	localparam logic signed [9:0] PR_B = -10'sd21;

	localparam logic signed [9:0] CHROMA_OFFSET = 10'sd128; // Centres Pb and Pr at mid scale

endpackage

// File: analogizer_snac_pkg.sv
// SNAC gamepad package with button word type, serial timing and reader states
package analogizer_snac_pkg;

	typedef logic [15:0] pad_word_t; // One pad, bit set means pressed

	localparam int PAD_BITS = 16; // Bits shifted per pad and poll

	// Serial clock derived from the fixed master clock
	localparam int MASTER_CLK_FREQ = 50_000_000;
	localparam int SERIAL_CLK_FREQ = 6_250_000;
	localparam int HALF_BIT_CYCLES = MASTER_CLK_FREQ / (2 * SERIAL_CLK_FREQ); // 4 cycles

	localparam int LATCH_CYCLES = 8; // Width of the OUT1 latch pulse

	// Poll sequencer
	typedef enum logic [2:0] {
		ST_IDLE,     // Waiting for a request
		ST_LATCH,    // OUT1 high, pads capture their buttons
		ST_CLK_LOW,  // OUT2 low, data sampled at the end
		ST_CLK_HIGH, // OUT2 high, pads advance after the rise
		ST_DONE      // Words committed, ack held until req drops
	} snac_state_t;

endpackage

// File: analogizer_ifs.sv
// Internal buses from the video encoder and the SNAC reader to the cartridge pin mapper
`timescale 1ns/1ps

// DAC word plus syncs and pixel strobe, ready for the bank pins
interface dac_pins_if import analogizer_video_pkg::*; ();
	dac_t r;
	dac_t g;
	dac_t b;
	logic hsync;   // HS pin of the DAC
	logic vsync;   // VS pin, or sync feed for the SOG switch
	logic blank_n;
	logic pix_stb; // Pixel strobe on the VID CLK pin

	modport src (output r, g, b, hsync, vsync, blank_n, pix_stb);
	modport dst (input r, g, b, hsync, vsync, blank_n, pix_stb);
endinterface

// Serial gamepad lines on the SNAC connector
interface snac_pins_if ();
	logic latch;   // OUT1
	logic pad_clk; // OUT2
	logic data1;   // IN4, pad one, active low
	logic data2;   // IN7, pad two, active low

	modport ctrl (output latch, pad_clk, input data1, data2);
	modport pins (input latch, pad_clk, output data1, data2);
endinterface

// File: ypbpr_converter.sv
// RGB to YPbPr colour matrix in two register stages with chroma offset and clamping
`timescale 1ns/1ps

module ypbpr_converter import analogizer_video_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	input  pixel_t i_r,
	input  pixel_t i_g,
	input  pixel_t i_b,
	input  logic   i_csync,
	output pixel_t o_y,
	output pixel_t o_pb,
	output pixel_t o_pr,
	output logic   o_csync
);
	logic signed [8:0] r_s; // Channels made signed for the matrix
	logic signed [8:0] g_s;
	logic signed [8:0] b_s;
	logic signed [17:0] prod_y [3];  // R, G and B terms
	logic signed [17:0] prod_pb [3];
	logic signed [17:0] prod_pr [3];
	logic signed [19:0] sum_y;
	logic signed [19:0] sum_pb;
	logic signed [19:0] sum_pr;
	logic [1:0] csync_sr; // Sync follows the two matrix stages

	// Saturate to the 8-bit output range
	function automatic pixel_t clamp_pixel(input logic signed [19:0] v);
		if (v < 0)
			return '0;
		else if (v > 255)
			return 8'd255;
		return v[7:0];
	endfunction

	assign r_s = $signed({1'b0, i_r});
	assign g_s = $signed({1'b0, i_g});
	assign b_s = $signed({1'b0, i_b});

	// Stage 1, nine products
	always_ff @(posedge i_clk) begin
		prod_y[0] <= 18'(Y_R) * 18'(r_s);
		prod_y[1] <= 18'(Y_G) * 18'(g_s);
		prod_y[2] <= 18'(Y_B) * 18'(b_s);
		prod_pb[0] <= 18'(PB_R) * 18'(r_s);
		prod_pb[1] <= 18'(PB_G) * 18'(g_s);
		prod_pb[2] <= 18'(PB_B) * 18'(b_s);
		prod_pr[0] <= 18'(PR_R) * 18'(r_s);
		prod_pr[1] <= 18'(PR_G) * 18'(g_s);
		prod_pr[2] <= 18'(PR_B) * 18'(b_s);
	end

	assign sum_y  = 20'(prod_y[0]) + 20'(prod_y[1]) + 20'(prod_y[2]);
	assign sum_pb = 20'(prod_pb[0]) + 20'(prod_pb[1]) + 20'(prod_pb[2]);
	assign sum_pr = 20'(prod_pr[0]) + 20'(prod_pr[1]) + 20'(prod_pr[2]);

	// Stage 2, scale back by 256, recentre chroma, saturate
	always_ff @(posedge i_clk) begin
		o_y  <= clamp_pixel(sum_y >>> 8);
		o_pb <= clamp_pixel((sum_pb >>> 8) + 20'(CHROMA_OFFSET));
		o_pr <= clamp_pixel((sum_pr >>> 8) + 20'(CHROMA_OFFSET));
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			csync_sr <= '0;
		else
			csync_sr <= {csync_sr[0], i_csync};
	end

	assign o_csync = csync_sr[1];

endmodule

// File: video_mode_encoder.sv
// Video output encoder with blanking, mode select and sync routing, all modes share one latency
`timescale 1ns/1ps

module video_mode_encoder import analogizer_video_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	input  video_mode_t i_video_mode,
	input  pixel_t      i_r,
	input  pixel_t      i_g,
	input  pixel_t      i_b,
	input  logic        i_hsync,
	input  logic        i_vsync,
	input  logic        i_csync,
	input  logic        i_blank_n,
	input  logic        i_ce_pix,
	dac_pins_if.src     dac
);
	// Everything that bypasses the colour matrix
	typedef struct packed {
		video_mode_t mode;
		dac_t        r;
		dac_t        g;
		dac_t        b;
		logic        hsync;
		logic        vsync;
		logic        csync;
		logic        blank_n;
		logic        ce_pix;
	} vid_stage_t;

	pixel_t r_bl; // Colour forced to black in blanking
	pixel_t g_bl;
	pixel_t b_bl;
	pixel_t y_conv;
	pixel_t pb_conv;
	pixel_t pr_conv;
	logic csync_conv;
	vid_stage_t stage_in;
	vid_stage_t stage_q [VIDEO_LATENCY-1]; // Matches the converter depth
	vid_stage_t stage_out;

	assign r_bl = i_blank_n ? i_r : '0;
	assign g_bl = i_blank_n ? i_g : '0;
	assign b_bl = i_blank_n ? i_b : '0;

	ypbpr_converter u_ypbpr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_r     (r_bl),
		.i_g     (g_bl),
		.i_b     (b_bl),
		.i_csync (i_csync),
		.o_y     (y_conv),
		.o_pb    (pb_conv),
		.o_pr    (pr_conv),
		.o_csync (csync_conv)
	);

	assign stage_in = '{i_video_mode, r_bl[7:2], g_bl[7:2], b_bl[7:2],
		i_hsync, i_vsync, i_csync, i_blank_n, i_ce_pix};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < VIDEO_LATENCY-1; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= stage_in;
			for (int i = 1; i < VIDEO_LATENCY-1; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign stage_out = stage_q[VIDEO_LATENCY-2];
	assign dac.pix_stb = stage_out.ce_pix;

	// Mode is taken from the delayed copy so colour and syncs stay paired
	always_comb begin
		dac.r = stage_out.r;
		dac.g = stage_out.g;
		dac.b = stage_out.b;
		dac.hsync = stage_out.csync; // RGBS default
		dac.vsync = 1'b1;
		dac.blank_n = stage_out.blank_n;
		case (stage_out.mode)
			MODE_RGSB: begin
				dac.hsync = 1'b1;
				dac.vsync = stage_out.csync; // Sync on green via SOG switch
			end
			MODE_YPBPR: begin
				dac.r = pr_conv[7:2];
				dac.g = y_conv[7:2];
				dac.b = pb_conv[7:2];
				dac.hsync = 1'b1;
				dac.vsync = csync_conv;
				dac.blank_n = 1'b1; // DAC must not blank the sync tip
			end
			MODE_TEST: begin
				dac.r = '0;
				dac.g = '0;
				dac.b = 6'd63;
				dac.hsync = stage_out.hsync; // Separate syncs for the test screen
				dac.vsync = stage_out.vsync;
			end
			default: ;
		endcase
	end

endmodule

// File: snac_gamepad_reader.sv
// Two-pad serial SNAC poller, started and finished by a four-phase req/ack handshake
`timescale 1ns/1ps

module snac_gamepad_reader import analogizer_snac_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_poll_req,
	output logic      o_poll_ack,
	output logic      o_busy,
	output pad_word_t o_p1_buttons,
	output pad_word_t o_p2_buttons,
	snac_pins_if.ctrl snac
);
	snac_state_t state;
	logic [$clog2(LATCH_CYCLES)-1:0] phase_cnt; // Cycles into latch or half bit
	logic [$clog2(PAD_BITS)-1:0] bit_cnt;       // Bit being clocked out
	pad_word_t shift1; // Assembles pad one, LSB first
	pad_word_t shift2;
	logic phase_end;   // Last cycle of the current phase
	logic last_bit;

	assign phase_end = (state == ST_LATCH) ? (int'(phase_cnt) == LATCH_CYCLES - 1)
		: (int'(phase_cnt) == HALF_BIT_CYCLES - 1);
	assign last_bit = int'(bit_cnt) == PAD_BITS - 1;

	// Pin levels and status decode straight from the state
	assign snac.latch = state == ST_LATCH;
	assign snac.pad_clk = state == ST_CLK_HIGH; // Idles low
	assign o_poll_ack = state == ST_DONE;
	assign o_busy = (state == ST_LATCH) || (state == ST_CLK_LOW) || (state == ST_CLK_HIGH);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= ST_IDLE;
			phase_cnt <= '0;
			bit_cnt <= '0;
			o_p1_buttons <= '0;
			o_p2_buttons <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					phase_cnt <= '0;
					bit_cnt <= '0;
					if (i_poll_req && !o_poll_ack) // New poll only on a fresh request
						state <= ST_LATCH;
				end
				ST_LATCH: begin
					phase_cnt <= phase_end ? '0 : phase_cnt + 1'b1;
					if (phase_end)
						state <= ST_CLK_LOW; // Bit 0 already on the wire
				end
				ST_CLK_LOW: begin
					phase_cnt <= phase_end ? '0 : phase_cnt + 1'b1;
					if (phase_end)
						state <= ST_CLK_HIGH;
				end
				ST_CLK_HIGH: begin
					phase_cnt <= phase_end ? '0 : phase_cnt + 1'b1;
					if (phase_end && last_bit) begin
						o_p1_buttons <= shift1; // Both words land together
						o_p2_buttons <= shift2;
						state <= ST_DONE;
					end else if (phase_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						state <= ST_CLK_LOW;
					end
				end
				ST_DONE: begin
					if (!i_poll_req) // Ack drops on the next edge
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Sample at the end of each low phase, wire is active low
	always_ff @(posedge i_clk) begin
		if (state == ST_CLK_LOW && phase_end) begin
			shift1 <= {~snac.data1, shift1[PAD_BITS-1:1]};
			shift2 <= {~snac.data2, shift2[PAD_BITS-1:1]};
		end
	end

endmodule

// File: cart_pin_mapper.sv
// Cartridge bank pin mapper, registers DAC and SNAC lines and holds pins idle when disabled
`timescale 1ns/1ps

module cart_pin_mapper import analogizer_video_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_ena,
	input  logic [7:4] i_bank0_in, // Bank0 is input only
	output logic [7:0] o_bank1_out,
	output logic [7:0] o_bank2_out,
	output logic [7:0] o_bank3_out,
	output logic       o_bank1_dir,
	output logic       o_bank2_dir,
	output logic       o_bank3_dir,
	dac_pins_if.dst    dac,
	snac_pins_if.pins  snac
);
	dac_t blue;    // Blue is split over bank2 and bank1
	logic pins_on; // Banks driven as outputs

	assign blue = dac.b;

	// SNAC inputs come straight off the connector
	assign snac.data1 = i_bank0_in[6]; // IN4
	assign snac.data2 = i_bank0_in[5]; // IN7

	// Enable acts on the same edge as the data, so pins follow i_ena one cycle later
	always_ff @(posedge i_clk) begin
		if (i_rst || !i_ena) begin
			o_bank3_out <= '0;
			o_bank2_out <= '0;
			o_bank1_out <= '0;
			pins_on <= 1'b0;
		end else begin
			o_bank3_out <= {dac.r, dac.hsync, dac.vsync};
			o_bank2_out <= {blue[0], dac.blank_n, dac.g};
			o_bank1_out <= {snac.pad_clk, snac.latch, dac.pix_stb, blue[5:1]};
			pins_on <= 1'b1;
		end
	end

	assign o_bank1_dir = pins_on;
	assign o_bank2_dir = pins_on;
	assign o_bank3_dir = pins_on;

endmodule

// File: analogizer_top.sv
// Analogizer adapter top, video encoder and SNAC poller joined onto the cartridge bank pins
`timescale 1ns/1ps

module analogizer_top import analogizer_video_pkg::*, analogizer_snac_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_ena,
	input  logic [1:0] i_video_mode,
	input  pixel_t     i_r,
	input  pixel_t     i_g,
	input  pixel_t     i_b,
	input  logic       i_hsync,
	input  logic       i_vsync,
	input  logic       i_csync,
	input  logic       i_blank_n,
	input  logic       i_ce_pix,
	input  logic       i_poll_req,
	input  logic [7:4] i_bank0_in,
	output logic       o_poll_ack,
	output logic       o_busy,
	output pad_word_t  o_p1_buttons,
	output pad_word_t  o_p2_buttons,
	output logic [7:0] o_bank1_out,
	output logic [7:0] o_bank2_out,
	output logic [7:0] o_bank3_out,
	output logic       o_bank1_dir,
	output logic       o_bank2_dir,
	output logic       o_bank3_dir
);
	dac_pins_if  dac_bus ();
	snac_pins_if snac_bus ();

	video_mode_encoder u_video (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_video_mode(video_mode_t'(i_video_mode)),
		.i_r(i_r), .i_g(i_g), .i_b(i_b),
		.i_hsync(i_hsync), .i_vsync(i_vsync), .i_csync(i_csync),
		.i_blank_n(i_blank_n), .i_ce_pix(i_ce_pix),
		.dac(dac_bus.src)
	);

	snac_gamepad_reader u_snac (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_poll_req(i_poll_req), .o_poll_ack(o_poll_ack), .o_busy(o_busy),
		.o_p1_buttons(o_p1_buttons), .o_p2_buttons(o_p2_buttons),
		.snac(snac_bus.ctrl)
	);

	cart_pin_mapper u_pins (
		.i_clk(i_clk), .i_rst(i_rst), .i_ena(i_ena), .i_bank0_in(i_bank0_in),
		.o_bank1_out(o_bank1_out), .o_bank2_out(o_bank2_out), .o_bank3_out(o_bank3_out),
		.o_bank1_dir(o_bank1_dir), .o_bank2_dir(o_bank2_dir), .o_bank3_dir(o_bank3_dir),
		.dac(dac_bus.dst), .snac(snac_bus.pins)
	);

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset source, 8 ns clock with reset held over the first two edges
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk; // 8 ns period
	end

	initial begin
		o_rst = 1'b1;
		repeat (2) @(posedge o_clk);
		#1 o_rst = 1'b0; // Drops with the same skew as the stimulus
	end
endmodule

// File: analogizer_top_assert.sv
// Bound checks on the poll handshake, the busy flag and the idle bank pins of the adapter top
`timescale 1ns/1ps

module analogizer_top_assert import analogizer_video_pkg::*, analogizer_snac_pkg::*; (
	input logic       i_clk,
	input logic       i_rst,
	input logic       i_ena,
	input logic       i_poll_req,
	input logic       i_poll_ack,
	input logic       i_busy,
	input pad_word_t  i_p1_buttons,
	input pad_word_t  i_p2_buttons,
	input logic [7:0] i_bank1_out,
	input logic [7:0] i_bank2_out,
	input logic [7:0] i_bank3_out,
	input logic       i_bank1_dir,
	input logic       i_bank2_dir,
	input logic       i_bank3_dir
);
	logic pins_idle; // All banks zero and set to input
	assign pins_idle = (i_bank1_out == '0) && (i_bank2_out == '0) && (i_bank3_out == '0)
		&& !i_bank1_dir && !i_bank2_dir && !i_bank3_dir;

	// Reset or disable idles every pin one edge later
	a_pins_idle: assert property (@(posedge i_clk) (i_rst || !i_ena) |=> pins_idle)
		else $error("Bank pins driven while in reset or disabled");
	a_reset_status: assert property (@(posedge i_clk) i_rst |=> !i_poll_ack && !i_busy)
		else $error("Ack or busy high after reset");

	// Four-phase poll handshake
	a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_poll_ack) |-> $past(i_poll_req)) else $error("Ack rose without a request");
	a_ack_holds: assert property (@(posedge i_clk) disable iff (i_rst)
		i_poll_ack && i_poll_req |=> i_poll_ack) else $error("Ack dropped while req high");
	a_ack_drops: assert property (@(posedge i_clk) disable iff (i_rst)
		i_poll_ack && !i_poll_req |=> !i_poll_ack) else $error("Ack stuck after req fell");

	// Busy spans the poll only
	a_busy_excl: assert property (@(posedge i_clk) disable iff (i_rst) !(i_busy && i_poll_ack))
		else $error("Busy and ack high together");
	a_busy_before_ack: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_poll_ack) |-> $past(i_busy)) else $error("Ack rose without a busy poll");
	a_busy_ends: assert property (@(posedge i_clk) disable iff (i_rst)
		$fell(i_busy) |-> i_poll_ack) else $error("Busy fell without ack");
	a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst) i_poll_ack |=> !i_busy)
		else $error("Second poll started from a held request");
	a_words_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		i_poll_ack |=> $stable(i_p1_buttons) && $stable(i_p2_buttons))
		else $error("Pad words changed while ack high");
endmodule

bind analogizer_top analogizer_top_assert u_top_assert (
	.i_clk(i_clk), .i_rst(i_rst), .i_ena(i_ena), .i_poll_req(i_poll_req),
	.i_poll_ack(o_poll_ack), .i_busy(o_busy),
	.i_p1_buttons(o_p1_buttons), .i_p2_buttons(o_p2_buttons),
	.i_bank1_out(o_bank1_out), .i_bank2_out(o_bank2_out), .i_bank3_out(o_bank3_out),
	.i_bank1_dir(o_bank1_dir), .i_bank2_dir(o_bank2_dir), .i_bank3_dir(o_bank3_dir)
);

// File: tb_analogizer_top.sv
// Adapter testbench, random video in every mode and gamepad polls against a serial pad model
`timescale 1ns/1ps

module tb_analogizer_top import analogizer_video_pkg::*, analogizer_snac_pkg::*; ();
	localparam int POLL_TIMEOUT = LATCH_CYCLES + PAD_BITS * 2 * HALF_BIT_CYCLES + 16;
	localparam int WATCHDOG_CYCLES = 20000;

	// Video inputs driven in one cycle
	typedef struct packed {
		video_mode_t mode;
		pixel_t      r;
		pixel_t      g;
		pixel_t      b;
		logic        hsync;
		logic        vsync;
		logic        csync;
		logic        blank_n;
		logic        ce_pix;
	} vid_in_t;

	logic clk;
	logic rst;
	logic ena;
	logic [1:0] video_mode;
	pixel_t pix_r;
	pixel_t pix_g;
	pixel_t pix_b;
	logic hsync;
	logic vsync;
	logic csync;
	logic blank_n;
	logic ce_pix;
	logic poll_req;
	logic [7:4] bank0_in;
	logic poll_ack;
	logic busy;
	pad_word_t p1_buttons;
	pad_word_t p2_buttons;
	logic [7:0] bank1_out;
	logic [7:0] bank2_out;
	logic [7:0] bank3_out;
	logic bank1_dir;
	logic bank2_dir;
	logic bank3_dir;

	vid_in_t hist [VIDEO_LATENCY]; // Newest first
	int hist_count;
	logic [31:0] rng_state;
	pad_word_t wire1;  // Wire levels the pads send, low means pressed
	pad_word_t wire2;
	pad_word_t sreg1;  // Pad shift registers
	pad_word_t sreg2;
	logic pad_clk_q;

	tb_clock_gen u_clock_gen (.o_clk(clk), .o_rst(rst));

	analogizer_top u_analogizer_top (
		.i_clk(clk), .i_rst(rst), .i_ena(ena), .i_video_mode(video_mode),
		.i_r(pix_r), .i_g(pix_g), .i_b(pix_b),
		.i_hsync(hsync), .i_vsync(vsync), .i_csync(csync),
		.i_blank_n(blank_n), .i_ce_pix(ce_pix),
		.i_poll_req(poll_req), .i_bank0_in(bank0_in),
		.o_poll_ack(poll_ack), .o_busy(busy),
		.o_p1_buttons(p1_buttons), .o_p2_buttons(p2_buttons),
		.o_bank1_out(bank1_out), .o_bank2_out(bank2_out), .o_bank3_out(bank3_out),
		.o_bank1_dir(bank1_dir), .o_bank2_dir(bank2_dir), .o_bank3_dir(bank3_dir)
	);

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic pixel_t saturate_byte(input int v);
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return 8'(v);
	endfunction

	// Expected {bank3, bank2, bank1} for one input set, pad lines idle
	function automatic logic [23:0] expected_pins(input vid_in_t v);
		int r;
		int g;
		int b;
		pixel_t y;
		pixel_t pb;
		pixel_t pr;
		dac_t r6;
		dac_t g6;
		dac_t b6;
		logic hs;
		logic vs;
		logic bl;
		r = v.blank_n ? int'(v.r) : 0; // Black during blanking
		g = v.blank_n ? int'(v.g) : 0;
		b = v.blank_n ? int'(v.b) : 0;
		y = saturate_byte((77 * r + 150 * g + 29 * b) >>> 8);
		pb = saturate_byte(((-43 * r - 85 * g + 128 * b) >>> 8) + 128);
		pr = saturate_byte(((128 * r - 107 * g - 21 * b) >>> 8) + 128);
		r6 = 6'(r >> 2);
		g6 = 6'(g >> 2);
		b6 = 6'(b >> 2);
		hs = v.csync; // RGBS carries csync on HS
		vs = 1'b1;
		bl = v.blank_n;
		case (v.mode)
			MODE_RGSB: begin
				hs = 1'b1;
				vs = v.csync;
			end
			MODE_YPBPR: begin
				r6 = pr[7:2];
				g6 = y[7:2];
				b6 = pb[7:2];
				hs = 1'b1;
				vs = v.csync;
				bl = 1'b1;
			end
			MODE_TEST: begin
				r6 = '0;
				g6 = '0;
				b6 = 6'd63;
				hs = v.hsync;
				vs = v.vsync;
			end
			default: ;
		endcase
		return {r6, hs, vs, b6[0], bl, g6, 2'b00, v.ce_pix, b6[5:1]};
	endfunction

	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		stop_on_failure();
	endtask

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s, %s: expected %0h, actual %0h", test, what, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#1; // Drive and sample just after the edge
	endtask

	task automatic wait_for_ack(input logic level, input int limit);
		int n;
		n = 0;
		while (poll_ack !== level && n < limit) begin
			step_cycle();
			n++;
		end
		if (poll_ack !== level)
			abort_run($sformatf("Poll ack did not go to %0b within %0d cycles", level, limit));
	endtask

	task automatic drive_video(input video_mode_t mode, output vid_in_t v);
		logic [31:0] rnd;
		rnd = next_random();
		v.mode = mode;
		v.r = rnd[7:0];
		v.g = rnd[15:8];
		v.b = rnd[23:16];
		v.hsync = rnd[24];
		v.vsync = rnd[25];
		v.csync = rnd[26];
		v.blank_n = |rnd[28:27]; // Blank about one cycle in four
		v.ce_pix = rnd[29];
		video_mode = mode;
		pix_r = v.r;
		pix_g = v.g;
		pix_b = v.b;
		hsync = v.hsync;
		vsync = v.vsync;
		csync = v.csync;
		blank_n = v.blank_n;
		ce_pix = v.ce_pix;
	endtask

	task automatic run_video_mode(input video_mode_t mode, input string test, input int cycles);
		vid_in_t v;
		logic [23:0] exp_pins;
		for (int n = 0; n < cycles; n++) begin
			step_cycle();
			if (hist_count >= VIDEO_LATENCY) begin
				exp_pins = expected_pins(hist[VIDEO_LATENCY-1]); // Pins show the oldest entry
				check_value(test, "bank3", 32'(exp_pins[23:16]), 32'(bank3_out));
				check_value(test, "bank2", 32'(exp_pins[15:8]), 32'(bank2_out));
				check_value(test, "bank1", 32'(exp_pins[7:0]), 32'(bank1_out));
				check_value(test, "dir", 32'd7, 32'({bank3_dir, bank2_dir, bank1_dir}));
			end
			drive_video(mode, v);
			for (int k = VIDEO_LATENCY - 1; k > 0; k--)
				hist[k] = hist[k-1];
			hist[0] = v;
			if (hist_count < VIDEO_LATENCY)
				hist_count++;
		end
	endtask

	task automatic run_poll(input string test);
		logic [31:0] rnd;
		pad_word_t exp1;
		pad_word_t exp2;
		rnd = next_random();
		wire1 = rnd[15:0];
		wire2 = rnd[31:16];
		exp1 = ~wire1; // Reader inverts the active low wire
		exp2 = ~wire2;
		poll_req = 1'b1;
		wait_for_ack(1'b1, POLL_TIMEOUT);
		check_value(test, "p1 buttons", 32'(exp1), 32'(p1_buttons));
		check_value(test, "p2 buttons", 32'(exp2), 32'(p2_buttons));
		repeat (40) begin // Long held req, no second poll
			step_cycle();
			check_value(test, "ack held", 32'd1, 32'(poll_ack));
			check_value(test, "busy after ack", 32'd0, 32'(busy));
		end
		poll_req = 1'b0;
		wait_for_ack(1'b0, 4);
		repeat (3) step_cycle();
	endtask

	// Pad model, loads on latch and shifts on each rising pad clock seen on bank1
	initial begin
		sreg1 = '1;
		sreg2 = '1;
		pad_clk_q = 1'b0;
		bank0_in = 4'b1111;
		forever begin
			step_cycle();
			if (bank1_out[6]) begin
				sreg1 = wire1;
				sreg2 = wire2;
			end else if (bank1_out[7] && !pad_clk_q) begin
				sreg1 = {1'b1, sreg1[PAD_BITS-1:1]};
				sreg2 = {1'b1, sreg2[PAD_BITS-1:1]};
			end
			pad_clk_q = bank1_out[7];
			bank0_in = {1'b1, sreg1[0], sreg2[0], 1'b1}; // IN4 on bit 6, IN7 on bit 5
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Simulation did not finish within the cycle limit");
	end

	initial begin
		int n;
		vid_in_t v;
		rng_state = 32'h00d5c899;
		hist_count = 0;
		wire1 = '1;
		wire2 = '1;
		ena = 1'b0;
		video_mode = MODE_RGBS;
		pix_r = '0;
		pix_g = '0;
		pix_b = '0;
		hsync = 1'b1;
		vsync = 1'b1;
		csync = 1'b1;
		blank_n = 1'b1;
		ce_pix = 1'b0;
		poll_req = 1'b0;
		n = 0;
		while (rst !== 1'b0 && n < 10) begin
			step_cycle();
			n++;
		end
		if (rst !== 1'b0)
			abort_run("Reset was never released");

		// Disabled, pins stay idle whatever the video does
		for (int k = 0; k < 12; k++) begin
			drive_video(MODE_RGBS, v);
			step_cycle();
			check_value("disabled", "banks", 32'd0, 32'({bank3_out, bank2_out, bank1_out}));
			check_value("disabled", "dir", 32'd0, 32'({bank3_dir, bank2_dir, bank1_dir}));
			check_value("disabled", "ack busy", 32'd0, 32'({poll_ack, busy}));
		end

		ena = 1'b1;
		hist_count = 0; // Pins were gated, refill before comparing
		run_video_mode(MODE_RGBS, "rgbs", 64);
		run_video_mode(MODE_RGSB, "rgsb", 64);
		run_video_mode(MODE_YPBPR, "ypbpr", 64);
		run_video_mode(MODE_TEST, "test_screen", 64);
		for (int k = 0; k < 4; k++)
			run_poll("poll");

		$display("Test passed");
		$finish;
	end
endmodule

// File: analogizer_top.f
analogizer_video_pkg.sv
analogizer_snac_pkg.sv
analogizer_ifs.sv
ypbpr_converter.sv
video_mode_encoder.sv
snac_gamepad_reader.sv
cart_pin_mapper.sv
analogizer_top.sv
tb_clock_gen.sv
analogizer_top_assert.sv
tb_analogizer_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the adapter testbench with Verilator and runs it, the exit status follows the run
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module tb_analogizer_top \
	--Mdir obj_dir \
	-f analogizer_top.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vtb_analogizer_top
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi
exit 0
